//--- Makefile
TOP = rvCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  rvPkg::aluOpT aluOp,
	input  rvPkg::wordT  x,
	input  rvPkg::wordT  y,
	output rvPkg::wordT  result
);

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = y[4:0];
	assign lessSigned = $signed(x) < $signed(y);
	assign lessUnsigned = x < y;

	always_comb
	begin
		case (aluOp)
			rvPkg::aluAdd: result = x + y;
			rvPkg::aluSub: result = x - y;
			rvPkg::aluSll: result = x << shamt;
			rvPkg::aluSrl: result = x >> shamt;
			rvPkg::aluSra: result = $signed(x) >>> shamt;  // keeps sign bit
			rvPkg::aluSlt: result = {31'b0, lessSigned};
			rvPkg::aluSltu: result = {31'b0, lessUnsigned};
			rvPkg::aluXor: result = x ^ y;
			rvPkg::aluOr: result = x | y;
			rvPkg::aluAnd: result = x & y;
			rvPkg::aluEq: result = {31'b0, x == y};
			rvPkg::aluNe: result = {31'b0, x != y};
			rvPkg::aluGeSigned: result = {31'b0, !lessSigned};
			rvPkg::aluGeUnsigned: result = {31'b0, !lessUnsigned};
			default: result = '0;
		endcase
	end

endmodule

//--- hw/coreControl.sv
`timescale 1ns/1ps

module coreControl (
	input                     clk,
	input                     reset,
	input  logic              instrValid,
	input  rvPkg::instrClassT instrClass,
	output logic              instrLatch,
	output logic              memRead,
	output logic              memWrite,
	output logic              regWrite,
	output logic              pcUpdate,
	output logic              retire,
	output logic              busy
);

	rvPkg::ctrlStateT state;
	rvPkg::ctrlStateT nextState;
	logic writesReg;

	always_comb
	begin
		nextState = state;
		case (state)
			rvPkg::stIdle:
				if (instrValid)
					nextState = rvPkg::stExecute;
			rvPkg::stExecute:
				nextState = (instrClass == rvPkg::classLoad) ? rvPkg::stMemory : rvPkg::stRetire;
			rvPkg::stMemory:
				nextState = rvPkg::stRetire;  // read data lands during this cycle
			default:
				nextState = rvPkg::stIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= rvPkg::stIdle;
		else
			state <= nextState;
	end

	// stores, branches and illegal opcodes leave the register file alone
	assign writesReg = (instrClass != rvPkg::classStore) && (instrClass != rvPkg::classBranch) &&
		(instrClass != rvPkg::classIllegal);

	assign instrLatch = (state == rvPkg::stIdle) && instrValid;
	assign memRead = (state == rvPkg::stExecute) && (instrClass == rvPkg::classLoad);
	assign memWrite = (state == rvPkg::stExecute) && (instrClass == rvPkg::classStore);
	assign retire = (state == rvPkg::stRetire);
	assign regWrite = retire && writesReg;
	assign pcUpdate = retire;  // pc moves on the edge that ends retire
	assign busy = (state != rvPkg::stIdle);

endmodule

//--- hw/dataMem.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module dataMem (
	input               clk,
	input               reset,
	input  rvPkg::wordT addr,
	input  logic        readEn,
	input  logic        writeEn,
	input  logic [1:0]  size,
	input  logic        isUnsigned,
	input  rvPkg::wordT writeData,
	output rvPkg::wordT readData
);

	localparam int IDX_BITS = $clog2(`DMEM_WORDS);

	rvPkg::wordT mem [0:`DMEM_WORDS-1];
	logic [IDX_BITS-1:0] wordIdx;
	logic [4:0] byteShift;
	logic [4:0] halfShift;
	rvPkg::wordT memWord;
	logic [7:0] byteVal;
	logic [15:0] halfVal;

	assign wordIdx = addr[IDX_BITS+1:2];  // byte address wraps at memory size
	assign byteShift = {addr[1:0], 3'b0};
	assign halfShift = {addr[1], 4'b0};  // bit 0 ignored for halfwords
	assign memWord = mem[wordIdx];
	assign byteVal = memWord[byteShift +: 8];
	assign halfVal = memWord[halfShift +: 16];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				mem[i] <= '0;
			readData <= '0;
		end
		else
		begin
			if (writeEn)
				case (size)
					2'd0: mem[wordIdx][byteShift +: 8] <= writeData[7:0];
					2'd1: mem[wordIdx][halfShift +: 16] <= writeData[15:0];
					default: mem[wordIdx] <= writeData;  // only the addressed lanes change
				endcase
			if (readEn)
				case (size)
					2'd0: readData <= isUnsigned ? {24'b0, byteVal} : {{24{byteVal[7]}}, byteVal};
					2'd1: readData <= isUnsigned ? {16'b0, halfVal} : {{16{halfVal[15]}}, halfVal};
					default: readData <= memWord;
				endcase
		end
	end

endmodule

//--- hw/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  rvPkg::wordT       instr,
	output rvPkg::instrClassT instrClass,
	output rvPkg::aluOpT      aluOp,
	output rvPkg::wordT       immediate,
	output logic              useImm,
	output logic              usePcAsX,
	output logic [1:0]        memSize,
	output logic              memUnsigned,
	output rvPkg::regIdxT     rd,
	output rvPkg::regIdxT     rs1,
	output rvPkg::regIdxT     rs2
);

	logic [6:0] opcode;
	logic [2:0] func3;
	rvPkg::aluOpT func3Op;  // arithmetic op picked by func3 alone

	assign opcode = instr[6:0];
	assign func3 = instr[14:12];
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign memSize = func3[1:0];
	assign memUnsigned = func3[2];

	always_comb
	begin
		case (func3)
			3'd0: func3Op = rvPkg::aluAdd;
			3'd1: func3Op = rvPkg::aluSll;
			3'd2: func3Op = rvPkg::aluSlt;
			3'd3: func3Op = rvPkg::aluSltu;
			3'd4: func3Op = rvPkg::aluXor;
			3'd5: func3Op = instr[30] ? rvPkg::aluSra : rvPkg::aluSrl;  // bit 30 also for srai
			3'd6: func3Op = rvPkg::aluOr;
			default: func3Op = rvPkg::aluAnd;
		endcase
	end

	always_comb
	begin
		instrClass = rvPkg::classIllegal;
		aluOp = rvPkg::aluAdd;
		immediate = {{20{instr[31]}}, instr[31:20]};  // I form
		case (opcode)
			7'b0110011:
			begin
				instrClass = rvPkg::classRegAlu;
				aluOp = (func3 == 3'd0 && instr[30]) ? rvPkg::aluSub : func3Op;
			end
			7'b0010011:
			begin
				instrClass = rvPkg::classImmAlu;
				aluOp = func3Op;  // no subi, so bit 30 only matters for shifts
			end
			7'b0000011:
				if (func3 != 3'd3 && func3 < 3'd6)
					instrClass = rvPkg::classLoad;
			7'b0100011:
			begin
				immediate = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				if (func3 < 3'd3)
					instrClass = rvPkg::classStore;
			end
			7'b1100011:
			begin
				immediate = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
				instrClass = rvPkg::classBranch;
				case (func3)
					3'd0: aluOp = rvPkg::aluEq;
					3'd1: aluOp = rvPkg::aluNe;
					3'd4: aluOp = rvPkg::aluSlt;
					3'd5: aluOp = rvPkg::aluGeSigned;
					3'd6: aluOp = rvPkg::aluSltu;
					3'd7: aluOp = rvPkg::aluGeUnsigned;
					default: instrClass = rvPkg::classIllegal;  // func3 2 and 3 unused
				endcase
			end
			7'b1101111:
			begin
				immediate = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
				instrClass = rvPkg::classJal;
			end
			7'b1100111:
				if (func3 == 3'd0)
					instrClass = rvPkg::classJalr;
			7'b0110111:
			begin
				immediate = {instr[31:12], 12'b0};
				instrClass = rvPkg::classLui;
			end
			7'b0010111:
			begin
				immediate = {instr[31:12], 12'b0};
				instrClass = rvPkg::classAuipc;
			end
			default: instrClass = rvPkg::classIllegal;
		endcase
	end

	// Y comes from the immediate for everything except R-type and branches
	assign useImm = (instrClass != rvPkg::classRegAlu) && (instrClass != rvPkg::classBranch);
	assign usePcAsX = (instrClass == rvPkg::classAuipc);

endmodule

//--- hw/pcCounter.sv
`timescale 1ns/1ps

module pcCounter (
	input               clk,
	input               reset,
	input  logic        pcUpdate,
	input  logic        branchTaken,
	input  rvPkg::wordT target,
	output rvPkg::wordT pc,
	output rvPkg::wordT retired
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			retired <= '0;
		end
		else if (pcUpdate)
		begin
			pc <= branchTaken ? target : pc + 32'd4;
			retired <= retired + 32'd1;  // one per retirement
		end
	end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module regFile (
	input                 clk,
	input                 reset,
	input  rvPkg::regIdxT rs1,
	input  rvPkg::regIdxT rs2,
	output rvPkg::wordT   rs1Data,
	output rvPkg::wordT   rs2Data,
	input  logic          writeEn,
	input  rvPkg::regIdxT rd,
	input  rvPkg::wordT   writeData
);

	rvPkg::wordT regs [0:`REG_COUNT-1];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (writeEn && rd != '0)  // x0 stays zero
			regs[rd] <= writeData;
	end

	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

endmodule

//--- hw/rvCore.sv
`timescale 1ns/1ps

module rvCore (
	input                 clk,
	input                 reset,
	input  logic          instrValid,
	input  rvPkg::wordT   instr,
	output logic          retire,
	output logic          wbEn,
	output rvPkg::regIdxT wbReg,
	output rvPkg::wordT   wbData,
	output rvPkg::wordT   pc,
	output logic          busy
);

	rvPkg::wordT instrReg;
	rvPkg::instrClassT instrClass;
	rvPkg::aluOpT aluOp;
	rvPkg::wordT immediate;
	logic useImm;
	logic usePcAsX;
	logic [1:0] memSize;
	logic memUnsigned;
	rvPkg::regIdxT rdIdx;
	rvPkg::regIdxT rs1Idx;
	rvPkg::regIdxT rs2Idx;
	rvPkg::wordT rs1Data;
	rvPkg::wordT rs2Data;
	rvPkg::wordT aluX;
	rvPkg::wordT aluY;
	rvPkg::wordT aluResult;
	rvPkg::wordT loadData;
	rvPkg::wordT target;
	rvPkg::wordT retiredCount;  // retirements since reset
	logic instrLatch;
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic pcUpdate;
	logic branchTaken;

	always_ff @(posedge clk)
	begin
		if (instrLatch)
			instrReg <= instr;
	end

	instrDecode u_decode (
		.instr(instrReg), .instrClass(instrClass), .aluOp(aluOp), .immediate(immediate),
		.useImm(useImm), .usePcAsX(usePcAsX), .memSize(memSize), .memUnsigned(memUnsigned),
		.rd(rdIdx), .rs1(rs1Idx), .rs2(rs2Idx)
	);

	coreControl u_control (
		.clk(clk), .reset(reset), .instrValid(instrValid), .instrClass(instrClass),
		.instrLatch(instrLatch), .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
		.pcUpdate(pcUpdate), .retire(retire), .busy(busy)
	);

	regFile u_regs (
		.clk(clk), .reset(reset), .rs1(rs1Idx), .rs2(rs2Idx), .rs1Data(rs1Data),
		.rs2Data(rs2Data), .writeEn(regWrite), .rd(rdIdx), .writeData(wbData)
	);

	assign aluX = usePcAsX ? pc : rs1Data;   // auipc
	assign aluY = useImm ? immediate : rs2Data;

	aluUnit u_alu (.aluOp(aluOp), .x(aluX), .y(aluY), .result(aluResult));

	dataMem u_dmem (
		.clk(clk), .reset(reset), .addr(aluResult), .readEn(memRead), .writeEn(memWrite),
		.size(memSize), .isUnsigned(memUnsigned), .writeData(rs2Data), .readData(loadData)
	);

	always_comb
	begin
		case (instrClass)
			rvPkg::classLoad: wbData = loadData;
			rvPkg::classJal, rvPkg::classJalr: wbData = pc + 32'd4;  // link address
			rvPkg::classLui: wbData = immediate;
			default: wbData = aluResult;
		endcase
	end

	assign branchTaken = (instrClass == rvPkg::classJal) || (instrClass == rvPkg::classJalr) ||
		((instrClass == rvPkg::classBranch) && aluResult[0]);
	assign target = (instrClass == rvPkg::classJalr) ? {aluResult[31:1], 1'b0} : pc + immediate;

	pcCounter u_pc (
		.clk(clk), .reset(reset), .pcUpdate(pcUpdate), .branchTaken(branchTaken),
		.target(target), .pc(pc), .retired(retiredCount)
	);

	assign wbEn = regWrite && (rdIdx != '0);
	assign wbReg = rdIdx;

endmodule

//--- hw/rvPkg.sv
`include "rv_macros.svh"

package rvPkg;

	typedef logic [`XLEN-1:0] wordT;                    // register, ALU and memory value
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;     // register number

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt,
		aluSltu,
		aluXor,
		aluOr,
		aluAnd,
		aluEq,
		aluNe,
		aluGeSigned,
		aluGeUnsigned
	} aluOpT;

	typedef enum logic [3:0] {
		classRegAlu,
		classImmAlu,
		classLoad,
		classStore,
		classBranch,
		classJal,
		classJalr,
		classLui,
		classAuipc,
		classIllegal
	} instrClassT;

	typedef enum logic [1:0] {
		stIdle,
		stExecute,
		stMemory,
		stRetire
	} ctrlStateT;

endpackage

//--- hw/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width of the core
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// data memory depth in 32-bit words, 256 bytes in total
`define DMEM_WORDS 64

`endif

//--- sim/rvCoreTb.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rvCoreTb;

	localparam int MEM_BYTES = `DMEM_WORDS * 4;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;

	logic clk;
	logic reset;
	logic instrValid;
	rvPkg::wordT instr;
	logic retire;
	logic wbEn;
	rvPkg::regIdxT wbReg;
	rvPkg::wordT wbData;
	rvPkg::wordT pc;
	logic busy;

	rvPkg::wordT modelRegs [0:`REG_COUNT-1];
	logic [7:0] modelMem [0:MEM_BYTES-1];
	rvPkg::wordT modelPc;
	rvPkg::wordT modelRetired;
	rvPkg::wordT curInstr;
	int checks;
	int errors;
	bit aborted;

	rvCore i_dut (
		.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr), .retire(retire),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .pc(pc), .busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic rvPkg::wordT rType(logic [6:0] f7, rvPkg::regIdxT rs2, rvPkg::regIdxT rs1,
		logic [2:0] f3, rvPkg::regIdxT rd);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic rvPkg::wordT iType(logic [11:0] imm, rvPkg::regIdxT rs1, logic [2:0] f3,
		rvPkg::regIdxT rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rvPkg::wordT sType(logic [11:0] imm, rvPkg::regIdxT rs2, rvPkg::regIdxT rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic rvPkg::wordT bType(logic [12:0] imm, rvPkg::regIdxT rs2, rvPkg::regIdxT rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rvPkg::wordT jType(logic [20:0] imm, rvPkg::regIdxT rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic rvPkg::regIdxT pickReg();
		return rvPkg::regIdxT'($urandom % 8);  // x0..x7 only
	endfunction

	// integer op as the ISA defines it, alt selects sub and sra
	function automatic rvPkg::wordT arith(logic [2:0] f3, bit alt, rvPkg::wordT a, rvPkg::wordT b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic rvPkg::wordT loadModel(rvPkg::wordT addr, logic [2:0] f3);
		logic [7:0] b0;
		logic [7:0] b1;
		int base;
		base = int'(addr % MEM_BYTES);  // address wraps at memory size
		case (f3[1:0])
			2'd0:
				return f3[2] ? {24'b0, modelMem[base]} : {{24{modelMem[base][7]}}, modelMem[base]};
			2'd1:
			begin
				base = base - base % 2;
				b0 = modelMem[base];
				b1 = modelMem[base + 1];
				return f3[2] ? {16'b0, b1, b0} : {{16{b1[7]}}, b1, b0};
			end
			default:
			begin
				base = base - base % 4;
				return {modelMem[base + 3], modelMem[base + 2], modelMem[base + 1], modelMem[base]};
			end
		endcase
	endfunction

	task automatic storeModel(input rvPkg::wordT addr, input logic [2:0] f3, input rvPkg::wordT v);
		int base;
		int n;
		base = int'(addr % MEM_BYTES);
		n = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
		base = base - base % n;  // lanes aligned to access size
		for (int i = 0; i < n; i++)
			modelMem[base + i] = v[8*i +: 8];
	endtask

	task automatic modelExecute(input rvPkg::wordT ins, output bit expEn,
		output rvPkg::regIdxT expRd, output rvPkg::wordT expData, output rvPkg::wordT expPc,
		output int expLatency);
		logic [2:0] f3;
		rvPkg::wordT a;
		rvPkg::wordT b;
		rvPkg::wordT immI;
		rvPkg::wordT immS;
		rvPkg::wordT immB;
		rvPkg::wordT immJ;
		rvPkg::wordT res;
		bit writes;
		bit taken;
		f3 = ins[14:12];
		a = modelRegs[ins[19:15]];
		b = modelRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		expPc = modelPc + 32'd4;
		expLatency = 2;
		writes = 1'b0;
		res = '0;
		case (ins[6:0])
			OP_REG:
			begin
				writes = 1'b1;
				res = arith(f3, ins[30], a, b);
			end
			OP_IMM:
			begin
				writes = 1'b1;
				res = arith(f3, ins[30] && f3 == 3'd5, a, immI);  // no subi
			end
			7'b0000011:
				if (f3 != 3'd3 && f3 < 3'd6)
				begin
					writes = 1'b1;
					expLatency = 3;
					res = loadModel(a + immI, f3);
				end
			7'b0100011:
				if (f3 < 3'd3)
					storeModel(a + immS, f3, b);
			7'b1100011:
				if (f3 != 3'd2 && f3 != 3'd3)
				begin
					case (f3)
						3'd0: taken = (a == b);
						3'd1: taken = (a != b);
						3'd4: taken = ($signed(a) < $signed(b));
						3'd5: taken = ($signed(a) >= $signed(b));
						3'd6: taken = (a < b);
						default: taken = (a >= b);
					endcase
					if (taken)
						expPc = modelPc + immB;
				end
			7'b1101111:
			begin
				writes = 1'b1;
				res = modelPc + 32'd4;
				expPc = modelPc + immJ;
			end
			7'b1100111:
				if (f3 == 3'd0)
				begin
					writes = 1'b1;
					res = modelPc + 32'd4;
					expPc = (a + immI) & ~32'd1;
				end
			7'b0110111:
			begin
				writes = 1'b1;
				res = {ins[31:12], 12'b0};
			end
			7'b0010111:
			begin
				writes = 1'b1;
				res = modelPc + {ins[31:12], 12'b0};
			end
			default:
				writes = 1'b0;  // unsupported, just pc+4
		endcase
		expRd = ins[11:7];
		expEn = writes && expRd != '0;
		expData = res;
		if (expEn)
			modelRegs[expRd] = res;
		modelPc = expPc;
		modelRetired = modelRetired + 32'd1;
	endtask

	task automatic checkValue(input string what, input rvPkg::wordT got, input rvPkg::wordT exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Mismatch at %0t: %s for instr %h, got %h expected %h",
				$time, what, curInstr, got, exp);
		end
	endtask

	task automatic issueInstr(input rvPkg::wordT ins);
		bit expEn;
		rvPkg::regIdxT expRd;
		rvPkg::wordT expData;
		rvPkg::wordT expPc;
		int expLatency;
		int waited;
		if (aborted)
			return;
		curInstr = ins;
		modelExecute(ins, expEn, expRd, expData, expPc, expLatency);
		instr = ins;
		instrValid = 1'b1;
		@(negedge clk);
		instrValid = 1'b0;
		instr = '0;
		checkValue("busy", 32'(busy), 32'd1);
		waited = 1;
		while (!retire && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (!retire)
		begin
			errors++;
			aborted = 1'b1;
			$display("Timeout: instruction %h did not retire within 20 cycles", ins);
			return;
		end
		checkValue("retire latency", waited, expLatency);
		checkValue("wbEn", 32'(wbEn), 32'(expEn));
		if (expEn)
		begin
			checkValue("wbReg", 32'(wbReg), 32'(expRd));
			checkValue("wbData", wbData, expData);
		end
		@(negedge clk);  // pc moves on the edge that ends retire
		checkValue("pc", pc, expPc);
		checkValue("busy", 32'(busy), 32'd0);
		checkValue("retired count", i_dut.retiredCount, modelRetired);
	endtask

	function automatic rvPkg::wordT randomInstr(int mix);
		int k;
		bit alt;
		logic [2:0] f3;
		logic [11:0] imm;
		rvPkg::wordT r;
		k = int'($urandom % 4);
		alt = 1'($urandom % 2);
		f3 = 3'($urandom % 8);
		imm = 12'($urandom);
		r = $urandom;
		case (mix)
			1:
				return rType((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, pickReg(),
					pickReg(), f3, pickReg());
			2:
			begin
				if (f3 == 3'd1)
					imm = {7'h00, imm[4:0]};
				else if (f3 == 3'd5)
					imm = {alt ? 7'h20 : 7'h00, imm[4:0]};  // srai or srli
				if (k < 2)
					return iType(imm, pickReg(), f3, pickReg(), OP_IMM);
				return {r[31:12], pickReg(), (k == 2) ? 7'b0110111 : 7'b0010111};
			end
			3:
			begin
				if (alt)
					return sType(imm, pickReg(), pickReg(), 3'($urandom % 3));
				f3 = 3'($urandom % 5);
				if (f3 >= 3'd3)
					f3 = f3 + 3'd1;  // 0 1 2 4 5
				return iType(imm, pickReg(), f3, pickReg(), 7'b0000011);
			end
			4:
			begin
				if (k < 2)
				begin
					f3 = 3'($urandom % 6);
					if (f3 >= 3'd2)
						f3 = f3 + 3'd2;  // skip unused 2 and 3
					return bType(r[12:0], pickReg(), pickReg(), f3);
				end
				if (k == 2)
					return jType(r[20:0], pickReg());
				return iType(imm, pickReg(), 3'd0, pickReg(), 7'b1100111);
			end
			default:
			begin
				if (k == 0)
					return rType(7'h00, pickReg(), pickReg(), f3 == 3'd5 ? 3'd0 : f3, '0);
				if (k == 1)
					return iType(imm, pickReg(), 3'd0, '0, OP_IMM);
				if (k == 3)
					return rType(7'h00, pickReg(), '0, 3'd0, pickReg());  // reads x0
				case ($urandom % 3)
					0: r[6:0] = 7'b0001111;  // fence
					1: r[6:0] = 7'b1110011;  // system
					default: r[6:0] = 7'b1111111;
				endcase
				return r;
			end
		endcase
	endfunction

	task automatic seedRegs();
		rvPkg::wordT v;
		for (int i = 1; i < 8; i++)
		begin
			v = $urandom;
			issueInstr({v[31:12], rvPkg::regIdxT'(i), 7'b0110111});
			issueInstr(iType(v[11:0], rvPkg::regIdxT'(i), 3'd4, rvPkg::regIdxT'(i), OP_IMM));
		end
	endtask

	task automatic runMix(input int mix, input string name, input int count);
		int c0;
		int e0;
		c0 = checks;
		e0 = errors;
		for (int i = 0; i < count; i++)
			issueInstr(randomInstr(mix == 6 ? 1 + int'($urandom % 4) : mix));
		$display("test %0d %s: %0d checks, %0d errors", mix, name, checks - c0, errors - e0);
	endtask

	initial
	begin
		int seedDummy;
		instrValid = 1'b0;
		instr = '0;
		reset = 1'b1;
		checks = 0;
		errors = 0;
		aborted = 1'b0;
		curInstr = '0;
		modelPc = '0;
		modelRetired = '0;
		seedDummy = $urandom(94729);
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < MEM_BYTES; i++)
			modelMem[i] = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		seedRegs();
		runMix(1, "register ALU", 200);
		runMix(2, "immediate and upper forms", 200);
		runMix(3, "loads and stores", 300);
		runMix(4, "branches and jumps", 200);
		runMix(5, "x0 and illegal opcodes", 150);
		runMix(6, "retire latency", 150);
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !aborted)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- sim/rvCore_props.sv
`timescale 1ns/1ps

module rvCoreProps (
	input                 clk,
	input                 reset,
	input  logic          instrValid,
	input  logic          retire,
	input  logic          busy,
	input  rvPkg::wordT   x0Value
);

	assert property (@(posedge clk) disable iff (reset) retire |=> !retire)
		else $error("retire held longer than one cycle");

	// accepted only in idle, loads take the longest path
	assert property (@(posedge clk) disable iff (reset)
		(instrValid && !busy) |-> ##3 (retire || $past(retire) || $past(retire, 2)))
		else $error("no retire within 3 cycles of an accepted instruction");

	assert property (@(posedge clk) reset |=> !busy)
		else $error("busy high right after reset");

	assert property (@(posedge clk) disable iff (reset) x0Value == '0)
		else $error("register x0 written with a nonzero value");

endmodule

bind rvCore rvCoreProps i_props (
	.clk(clk), .reset(reset), .instrValid(instrValid), .retire(retire), .busy(busy),
	.x0Value(u_regs.regs[0])
);

//--- vlog.f
+incdir+hw
hw/rvPkg.sv
hw/instrDecode.sv
hw/aluUnit.sv
hw/regFile.sv
hw/dataMem.sv
hw/coreControl.sv
hw/pcCounter.sv
hw/rvCore.sv
sim/rvCore_props.sv
sim/rvCoreTb.sv
